/* alu_execute.sv */
// ==========================================================================
// execute stage with forwarding from its own last result, ALU and branches
// redirect and exception strobes are combinational in the execute cycle
// nothing writes or retires while kill is high
// ==========================================================================
`include "core_defs.svh"

module alu_execute (
	input  logic               clk,
	input  logic               rst,
	input  logic               kill,
	input  pipe_pkg::id2ex_t   id_ex,
	output pipe_pkg::wb_t      wb_out,
	output logic               redirect,
	output logic [`XLEN-1:0]   redirect_pc,
	output logic               exc_valid,
	output isa_pkg::exc_code_e exc_code,
	output logic [`XLEN-1:0]   exc_epc,
	output logic               retire
);
	import isa_pkg::*;

	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_rt;
	logic [`XLEN-1:0] op_b;
	logic [`XLEN-1:0] result;
	logic             live;
	logic             taken;

	// wb_out.valid already implies a nonzero address
	function automatic logic [`XLEN-1:0] fwd(input pipe_pkg::wb_t w,
	                                          input logic [`REG_ADDR_W-1:0] a,
	                                          input logic [`XLEN-1:0] d);
		return (w.valid && w.addr == a) ? w.data : d;
	endfunction

	assign op_a  = fwd(wb_out, id_ex.rs_addr, id_ex.rs_data);
	assign op_rt = fwd(wb_out, id_ex.rt_addr, id_ex.rt_data);
	assign op_b  = id_ex.use_imm ? id_ex.imm : op_rt;
	assign live  = id_ex.valid && !kill;

	always_comb begin
		case (id_ex.alu_op)
			ALU_ADD:   result = op_a + op_b;
			ALU_SUB:   result = op_a - op_b;
			ALU_AND:   result = op_a & op_b;
			ALU_OR:    result = op_a | op_b;
			ALU_XOR:   result = op_a ^ op_b;
			ALU_SLT:   result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLL:   result = op_b << id_ex.shamt;
			ALU_PASS2: result = op_b;
			default:   result = '0;
		endcase
	end

	always_comb begin
		case (id_ex.branch_op)
			BR_EQ:     taken = (op_a == op_rt);
			BR_NE:     taken = (op_a != op_rt);
			BR_UNCOND: taken = 1'b1;
			default:   taken = 1'b0;
		endcase
	end

	assign exc_valid = live && id_ex.exc_code != EXC_NONE;
	assign exc_code  = id_ex.exc_code;
	assign exc_epc   = id_ex.in_delay_slot ? id_ex.pc - `XLEN'(4) : id_ex.pc;	// branch pc
	assign retire    = live && id_ex.exc_code == EXC_NONE;
	assign redirect  = retire && taken;

	// jr is the only unconditional jump that passes a register through the ALU
	assign redirect_pc = (id_ex.branch_op == BR_UNCOND && id_ex.alu_op == ALU_PASS2)
		? result : id_ex.branch_target;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_out <= '0;
		end else begin
			wb_out.valid <= retire && id_ex.wb_addr != '0;
			wb_out.addr  <= id_ex.wb_addr;
			wb_out.data  <= result;
		end
	end

endmodule

/* core_defs.svh */
// ==========================================================================
// core-wide widths and the fetch address taken on every start
// XLEN sets both the data width and the instruction address width
// ==========================================================================
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// data and address width
`define XLEN 32

// register index width, 32 registers
`define REG_ADDR_W 5

`define RESET_PC 32'h0000_0000	// first fetch after start

`endif

/* instr_decode.sv */
// ==========================================================================
// combinational decode of the fetched word into the execute payload
// LW, SW and every other unlisted word decode as EXC_RI
// JR passes rs as operand 2 so that execute can forward its target
// ==========================================================================
`include "core_defs.svh"

module instr_decode (
	input  pipe_pkg::if2id_t       if_id,
	input  logic [`XLEN-1:0]       rd_data1,
	input  logic [`XLEN-1:0]       rd_data2,
	output logic [`REG_ADDR_W-1:0] rd_addr1,
	output logic [`REG_ADDR_W-1:0] rd_addr2,
	output pipe_pkg::id2ex_t       id_ex
);
	import isa_pkg::*;

	logic [5:0]             opcode;
	logic [5:0]             funct;
	logic [`REG_ADDR_W-1:0] rs;
	logic [`REG_ADDR_W-1:0] rt;
	logic [`REG_ADDR_W-1:0] rd;
	logic [4:0]             shamt;
	logic [15:0]            imm16;
	logic [`XLEN-1:0]       imm_sext;
	logic [`XLEN-1:0]       imm_zext;
	logic [`XLEN-1:0]       pc_next;
	logic [`XLEN-1:0]       br_rel;
	logic [`XLEN-1:0]       br_region;
	alu_op_e                r_op;

	// plain register-register ops, ALU_NONE when the code is unknown
	function automatic alu_op_e rtype_op(input logic [5:0] fn);
		case (fn)
			FN_SLL:  return ALU_SLL;
			FN_ADDU: return ALU_ADD;
			FN_SUBU: return ALU_SUB;
			FN_AND:  return ALU_AND;
			FN_OR:   return ALU_OR;
			FN_XOR:  return ALU_XOR;
			FN_SLT:  return ALU_SLT;
			default: return ALU_NONE;
		endcase
	endfunction

	assign opcode = if_id.instr[31:26];
	assign rs     = if_id.instr[25:21];
	assign rt     = if_id.instr[20:16];
	assign rd     = if_id.instr[15:11];
	assign shamt  = if_id.instr[10:6];
	assign funct  = if_id.instr[5:0];
	assign imm16  = if_id.instr[15:0];

	assign imm_sext  = {{(`XLEN-16){imm16[15]}}, imm16};
	assign imm_zext  = {{(`XLEN-16){1'b0}}, imm16};
	assign pc_next   = if_id.pc + `XLEN'(4);
	assign br_rel    = pc_next + {imm_sext[`XLEN-3:0], 2'b00};
	assign br_region = {pc_next[31:28], if_id.instr[25:0], 2'b00};	// 256 MB region
	assign r_op      = rtype_op(funct);

	assign rd_addr1 = rs;
	assign rd_addr2 = rt;

	always_comb begin
		id_ex = '0;
		id_ex.valid         = if_id.valid;
		id_ex.pc            = if_id.pc;
		id_ex.in_delay_slot = if_id.in_delay_slot;
		id_ex.rs_addr       = rs;
		id_ex.rs_data       = rd_data1;
		id_ex.rt_addr       = rt;
		id_ex.rt_data       = rd_data2;
		id_ex.shamt         = shamt;
		id_ex.alu_op        = ALU_NONE;
		id_ex.branch_op     = BR_NONE;
		id_ex.branch_target = br_rel;
		id_ex.exc_code      = EXC_NONE;

		case (opcode)
			OP_SPECIAL: begin
				case (funct)
					FN_JR: begin
						id_ex.rt_addr   = rs;	// target rides on operand 2
						id_ex.rt_data   = rd_data1;
						id_ex.alu_op    = ALU_PASS2;
						id_ex.branch_op = BR_UNCOND;
					end
					FN_SYSCALL: id_ex.exc_code = EXC_SYS;
					default: begin
						if (r_op == ALU_NONE) begin
							id_ex.exc_code = EXC_RI;
						end else begin
							id_ex.alu_op  = r_op;
							id_ex.wb_addr = rd;	// rd of zero is a nop
						end
					end
				endcase
			end
			OP_J: begin
				id_ex.branch_op     = BR_UNCOND;
				id_ex.branch_target = br_region;
			end
			OP_BEQ: id_ex.branch_op = BR_EQ;
			OP_BNE: id_ex.branch_op = BR_NE;
			OP_ADDIU: begin
				id_ex.imm     = imm_sext;
				id_ex.use_imm = 1'b1;
				id_ex.alu_op  = ALU_ADD;
				id_ex.wb_addr = rt;
			end
			OP_ORI: begin
				id_ex.imm     = imm_zext;
				id_ex.use_imm = 1'b1;
				id_ex.alu_op  = ALU_OR;
				id_ex.wb_addr = rt;
			end
			OP_LUI: begin
				id_ex.imm     = {imm16, 16'h0000};
				id_ex.use_imm = 1'b1;
				id_ex.alu_op  = ALU_PASS2;
				id_ex.wb_addr = rt;
			end
			default: id_ex.exc_code = EXC_RI;
		endcase

		// bubble stays all zero
		if (!if_id.valid)
			id_ex = '0;
	end

endmodule

/* isa_pkg.sv */
// ==========================================================================
// MIPS-subset encodings and the control enums shared by decode and execute
// only the listed opcodes and function codes are recognised
// ==========================================================================
package isa_pkg;

	// primary opcodes, instr[31:26]
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_BNE     = 6'h05;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_LUI     = 6'h0f;

	// function codes under OP_SPECIAL, instr[5:0]
	localparam logic [5:0] FN_SLL     = 6'h00;
	localparam logic [5:0] FN_JR      = 6'h08;
	localparam logic [5:0] FN_SYSCALL = 6'h0c;
	localparam logic [5:0] FN_ADDU    = 6'h21;
	localparam logic [5:0] FN_SUBU    = 6'h23;
	localparam logic [5:0] FN_AND     = 6'h24;
	localparam logic [5:0] FN_OR      = 6'h25;
	localparam logic [5:0] FN_XOR     = 6'h26;
	localparam logic [5:0] FN_SLT     = 6'h2a;

	typedef enum logic [3:0] {
		ALU_NONE  = 4'd0,	// result is zero
		ALU_ADD   = 4'd1,
		ALU_SUB   = 4'd2,
		ALU_AND   = 4'd3,
		ALU_OR    = 4'd4,
		ALU_XOR   = 4'd5,
		ALU_SLT   = 4'd6,	// signed compare
		ALU_SLL   = 4'd7,	// operand 2 shifted by shamt
		ALU_PASS2 = 4'd8	// operand 2 as is
	} alu_op_e;

	typedef enum logic [1:0] {
		BR_NONE   = 2'd0,
		BR_EQ     = 2'd1,
		BR_NE     = 2'd2,
		BR_UNCOND = 2'd3
	} branch_op_e;

	// all-zero encodings so that a cleared payload is a harmless bubble
	typedef enum logic [1:0] {
		EXC_NONE = 2'd0,
		EXC_SYS  = 2'd1,
		EXC_RI   = 2'd2	// reserved or unsupported instruction
	} exc_code_e;

endpackage

/* list.f */
+incdir+.
isa_pkg.sv
pipe_pkg.sv
pc_counter.sv
pipe_ctrl.sv
stage_reg.sv
reg_file.sv
instr_decode.sv
alu_execute.sv
mips_core.sv
tb_mips_core.sv

/* mips_core.sv */
// ==========================================================================
// three-stage MIPS-subset core: fetch, decode, execute
// instruction memory is outside and read combinationally on imem_addr
// no data memory, no stalls, one branch delay slot
// ==========================================================================
`include "core_defs.svh"

module mips_core (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	output logic [`XLEN-1:0]   imem_addr,
	input  logic [`XLEN-1:0]   imem_data,
	output pipe_pkg::wb_t      wb_out,
	output logic               halted,
	output isa_pkg::exc_code_e exc_code,
	output logic [`XLEN-1:0]   exc_epc,
	output logic [31:0]        retired
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic                   fetch_en;
	logic                   flush_if;
	logic                   flush_ex;
	logic                   redirect;
	logic [`XLEN-1:0]       redirect_pc;
	logic                   retire;
	logic                   exc_valid;
	exc_code_e              ex_exc_code;
	logic [`XLEN-1:0]       ex_epc;
	logic [`XLEN-1:0]       pc;
	logic [`REG_ADDR_W-1:0] rd_addr1;
	logic [`REG_ADDR_W-1:0] rd_addr2;
	logic [`XLEN-1:0]       rd_data1;
	logic [`XLEN-1:0]       rd_data2;
	if2id_t                 if_id_d;
	if2id_t                 if_id_q;
	id2ex_t                 id_ex_d;
	id2ex_t                 id_ex_q;

	assign imem_addr = pc;

	always_comb begin
		if_id_d.valid         = fetch_en;
		if_id_d.pc            = pc;
		if_id_d.instr         = imem_data;
		if_id_d.in_delay_slot = (id_ex_d.branch_op != BR_NONE);	// branch now in decode
	end

	pc_counter u_pc (
		.clk(clk), .rst(rst), .start(start), .fetch_en(fetch_en),
		.redirect(redirect), .redirect_pc(redirect_pc), .retire(retire),
		.pc(pc), .retired(retired)
	);

	pipe_ctrl u_ctrl (
		.clk(clk), .rst(rst), .start(start),
		.exc_valid(exc_valid), .exc_code_in(ex_exc_code), .epc_in(ex_epc),
		.redirect(redirect), .fetch_en(fetch_en),
		.flush_if(flush_if), .flush_ex(flush_ex), .halted(halted),
		.exc_code(exc_code), .exc_epc(exc_epc)
	);

	stage_reg #(.payload_t(if2id_t)) u_if_id (
		.clk(clk), .rst(rst), .flush(flush_if), .d(if_id_d), .q(if_id_q)
	);

	reg_file u_rf (
		.clk(clk), .rst(rst), .rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
		.wr(wb_out), .rd_data1(rd_data1), .rd_data2(rd_data2)
	);

	instr_decode u_dec (
		.if_id(if_id_q), .rd_data1(rd_data1), .rd_data2(rd_data2),
		.rd_addr1(rd_addr1), .rd_addr2(rd_addr2), .id_ex(id_ex_d)
	);

	stage_reg #(.payload_t(id2ex_t)) u_id_ex (
		.clk(clk), .rst(rst), .flush(flush_ex), .d(id_ex_d), .q(id_ex_q)
	);

	alu_execute u_ex (
		.clk(clk), .rst(rst), .kill(halted), .id_ex(id_ex_q), .wb_out(wb_out),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.exc_valid(exc_valid), .exc_code(ex_exc_code), .exc_epc(ex_epc),
		.retire(retire)
	);

endmodule

/* pc_counter.sv */
// ==========================================================================
// fetch address and retired-instruction count
// a redirect wins over the sequential step, start wins over both
// ==========================================================================
`include "core_defs.svh"

module pc_counter (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	input  logic             fetch_en,
	input  logic             redirect,
	input  logic [`XLEN-1:0] redirect_pc,
	input  logic             retire,
	output logic [`XLEN-1:0] pc,
	output logic [31:0]      retired
);

	always_ff @(posedge clk) begin
		if (rst || start)
			pc <= `RESET_PC;
		else if (redirect)
			pc <= redirect_pc;	// taken branch resolved in execute
		else if (fetch_en)
			pc <= pc + `XLEN'(4);
	end

	// count restarts from zero on every start
	always_ff @(posedge clk) begin
		if (rst || start)
			retired <= '0;
		else if (retire)
			retired <= retired + 32'd1;
	end

endmodule

/* pipe_ctrl.sv */
// ==========================================================================
// run control: IDLE until start, RUN until an exception, HALT until start
// the exception report holds its value for the whole time in HALT
// ==========================================================================
`include "core_defs.svh"

module pipe_ctrl (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  logic                exc_valid,
	input  isa_pkg::exc_code_e  exc_code_in,
	input  logic [`XLEN-1:0]    epc_in,
	input  logic                redirect,
	output logic                fetch_en,
	output logic                flush_if,
	output logic                flush_ex,
	output logic                halted,
	output isa_pkg::exc_code_e  exc_code,
	output logic [`XLEN-1:0]    exc_epc
);
	import isa_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		HALT
	} state_t;

	state_t state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= IDLE;
			exc_code <= EXC_NONE;
			exc_epc  <= '0;
		end else begin
			case (state)
				IDLE: if (start) state <= RUN;
				RUN: begin
					if (exc_valid) begin
						state    <= HALT;
						exc_code <= exc_code_in;	// capture report
						exc_epc  <= epc_in;
					end
				end
				HALT: begin
					if (start) begin
						state    <= RUN;
						exc_code <= EXC_NONE;
						exc_epc  <= '0;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign fetch_en = (state == RUN);
	assign halted   = (state == HALT);

	// redirect drops the word after the delay slot
	assign flush_if = redirect || exc_valid;
	assign flush_ex = exc_valid;	// younger instruction in decode

endmodule

/* pipe_pkg.sv */
// ==========================================================================
// payloads passed between fetch, decode and execute, plus the write report
// an all-zero payload of any of these types is an invalid bubble
// ==========================================================================
`include "core_defs.svh"

package pipe_pkg;
	import isa_pkg::*;

	typedef struct packed {
		logic             valid;
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] instr;
		logic             in_delay_slot;	// word before this one was a branch
	} if2id_t;

	typedef struct packed {
		logic                   valid;
		logic [`XLEN-1:0]       pc;
		logic [`REG_ADDR_W-1:0] rs_addr;
		logic [`XLEN-1:0]       rs_data;
		logic [`REG_ADDR_W-1:0] rt_addr;
		logic [`XLEN-1:0]       rt_data;
		logic [`XLEN-1:0]       imm;	// operand 2 when use_imm is set
		logic                   use_imm;
		logic [4:0]             shamt;
		alu_op_e                alu_op;
		branch_op_e             branch_op;
		logic [`XLEN-1:0]       branch_target;
		logic [`REG_ADDR_W-1:0] wb_addr;	// zero means no write
		exc_code_e              exc_code;
		logic                   in_delay_slot;
	} id2ex_t;

	typedef struct packed {
		logic                   valid;
		logic [`REG_ADDR_W-1:0] addr;
		logic [`XLEN-1:0]       data;
	} wb_t;

endpackage

/* reg_file.sv */
// ==========================================================================
// 32 x 32 register file, two combinational reads, one write
// r0 is never written, a same-cycle write is visible on the read ports
// ==========================================================================
`include "core_defs.svh"

module reg_file (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`REG_ADDR_W-1:0] rd_addr1,
	input  logic [`REG_ADDR_W-1:0] rd_addr2,
	input  pipe_pkg::wb_t          wr,
	output logic [`XLEN-1:0]       rd_data1,
	output logic [`XLEN-1:0]       rd_data2
);

	localparam int DEPTH = 1 << `REG_ADDR_W;

	logic [`XLEN-1:0] regs [DEPTH];

	function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] a);
		if (a == '0)
			return '0;
		if (wr.valid && wr.addr == a)
			return wr.data;	// write-through
		return regs[a];
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++)
				regs[i] <= '0;
		end else if (wr.valid && wr.addr != '0) begin
			regs[wr.addr] <= wr.data;
		end
	end

	always_comb begin
		rd_data1 = read_port(rd_addr1);
		rd_data2 = read_port(rd_addr2);
	end

endmodule

/* stage_reg.sv */
// ==========================================================================
// pipeline register for any packed payload, loads every cycle
// reset and flush both leave an all-zero bubble
// ==========================================================================
module stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	always_ff @(posedge clk) begin
		if (rst || flush)
			q <= '0;	// valid bit low
		else
			q <= d;
	end

endmodule

/* tb_mips_core.sv */
// ==========================================================================
// testbench for mips_core with a combinational 64-word ROM and an ISA model
// two programs run back to back and share the register file state
// ==========================================================================
`include "core_defs.svh"

module tb_mips_core;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int WAIT_LIMIT = 200;	// cycles per wait

	typedef struct packed {
		logic [`REG_ADDR_W-1:0] addr;
		logic [`XLEN-1:0]       data;
	} wr_t;

	logic             clk;
	logic             rst;
	logic             start;
	logic [`XLEN-1:0] imem_addr;
	logic [`XLEN-1:0] imem_data;
	wb_t              wb_out;
	logic             halted;
	exc_code_e        exc_code;
	logic [`XLEN-1:0] exc_epc;
	logic [31:0]      retired;

	logic [`XLEN-1:0] rom [64];
	logic [`XLEN-1:0] mregs [32];	// model register state
	wr_t              exp_q [$];
	wr_t              exp_head;
	integer           seed = 32'hec0f4162;
	int               checks = 0;
	int               errors = 0;

	mips_core uut (
		.clk(clk), .rst(rst), .start(start), .imem_addr(imem_addr),
		.imem_data(imem_data), .wb_out(wb_out), .halted(halted),
		.exc_code(exc_code), .exc_epc(exc_epc), .retired(retired)
	);

	assign imem_data = rom[imem_addr[7:2]];	// upper address bits ignored

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] rtype_word(input logic [5:0] fn, input logic [4:0] rs,
	                                           input logic [4:0] rt, input logic [4:0] rd,
	                                           input logic [4:0] sh);
		return {OP_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
	                                           input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jump_word(input logic [31:0] target);
		return {OP_J, target[27:2]};
	endfunction

	task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("FAILED %s: got %h expected %h", name, got, want);
		end
	endtask

	task automatic load_program(input int sel);
		logic [15:0] imm [4];
		for (int i = 0; i < 4; i++)
			imm[i] = 16'($random(seed));
		for (int i = 0; i < 64; i++)
			rom[i] = {6'h3f, 26'(i * 4)};	// reserved opcode over the byte address
		if (sel == 0) begin
			rom[0]  = itype_word(OP_ADDIU, 5'd0, 5'd1, imm[0]);
			rom[1]  = itype_word(OP_ORI, 5'd0, 5'd2, imm[1]);
			rom[2]  = rtype_word(FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0);	// r1 via write-through
			rom[3]  = rtype_word(FN_SUBU, 5'd3, 5'd1, 5'd4, 5'd0);
			rom[4]  = itype_word(OP_LUI, 5'd0, 5'd5, imm[2]);
			rom[5]  = itype_word(OP_ORI, 5'd5, 5'd5, imm[3]);
			rom[6]  = rtype_word(FN_AND, 5'd5, 5'd3, 5'd6, 5'd0);
			rom[7]  = rtype_word(FN_OR, 5'd6, 5'd4, 5'd7, 5'd0);
			rom[8]  = rtype_word(FN_XOR, 5'd7, 5'd5, 5'd8, 5'd0);
			rom[9]  = rtype_word(FN_SLT, 5'd4, 5'd3, 5'd9, 5'd0);
			rom[10] = rtype_word(FN_SLL, 5'd0, 5'd8, 5'd10, 5'd5);
			rom[11] = itype_word(OP_ADDIU, 5'd1, 5'd0, 16'd7);	// r0 stays zero
			rom[12] = itype_word(OP_BEQ, 5'd1, 5'd1, 16'd2);
			rom[13] = itype_word(OP_ADDIU, 5'd0, 5'd11, 16'd1);
			rom[14] = itype_word(OP_ADDIU, 5'd0, 5'd11, 16'h0099);	// skipped
			rom[15] = itype_word(OP_BNE, 5'd1, 5'd1, 16'd5);	// not taken
			rom[16] = itype_word(OP_ADDIU, 5'd0, 5'd12, 16'd2);
			rom[17] = itype_word(OP_BNE, 5'd11, 5'd12, 16'd2);
			rom[18] = rtype_word(FN_ADDU, 5'd11, 5'd12, 5'd13, 5'd0);
			rom[19] = itype_word(OP_ADDIU, 5'd0, 5'd13, 16'h0055);
			rom[20] = jump_word(32'h0000_0060);
			rom[21] = rtype_word(FN_SLL, 5'd0, 5'd13, 5'd14, 5'd2);
			rom[22] = itype_word(OP_ADDIU, 5'd0, 5'd14, 16'h0077);
			rom[24] = itype_word(OP_ADDIU, 5'd0, 5'd15, 16'h0074);
			rom[25] = rtype_word(FN_JR, 5'd15, 5'd0, 5'd0, 5'd0);	// target forwarded
			rom[26] = itype_word(OP_ADDIU, 5'd0, 5'd16, 16'd3);
			rom[27] = itype_word(OP_ADDIU, 5'd0, 5'd16, 16'h0066);
			rom[28] = itype_word(OP_ADDIU, 5'd0, 5'd16, 16'h0088);
			rom[29] = rtype_word(FN_ADDU, 5'd16, 5'd15, 5'd17, 5'd0);
			rom[30] = rtype_word(FN_SYSCALL, 5'd0, 5'd0, 5'd0, 5'd0);
			rom[31] = itype_word(OP_ADDIU, 5'd0, 5'd18, 16'd9);
		end else begin
			rom[0] = itype_word(OP_ADDIU, 5'd0, 5'd20, imm[0]);
			rom[1] = itype_word(OP_BEQ, 5'd20, 5'd20, 16'd4);
			rom[2] = itype_word(6'h23, 5'd0, 5'd21, 16'h0000);	// LW in the delay slot
		end
	endtask

	// architectural model stepping one instruction at a time with one delay slot
	task automatic run_model(output exc_code_e code, output logic [`XLEN-1:0] epc,
	                         output int count);
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] npc;
		logic [`XLEN-1:0] instr;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		logic [`XLEN-1:0] res;
		logic [`XLEN-1:0] sext;
		logic [`XLEN-1:0] target;
		logic [4:0]       dst;
		logic             br;
		logic             taken;
		logic             prev_br;
		int               steps;
		wr_t              w;
		pc = `RESET_PC;
		npc = pc + 4;
		prev_br = 1'b0;
		code = EXC_NONE;
		epc = '0;
		count = 0;
		steps = 0;
		while (code == EXC_NONE && steps < WAIT_LIMIT) begin
			instr = rom[pc[7:2]];
			a = mregs[instr[25:21]];
			b = mregs[instr[20:16]];
			sext = {{16{instr[15]}}, instr[15:0]};
			dst = (instr[31:26] == OP_SPECIAL) ? instr[15:11] : instr[20:16];
			res = '0;
			br = 1'b0;
			taken = 1'b0;
			target = pc + 4 + (sext << 2);
			case (instr[31:26])
				OP_SPECIAL: begin
					case (instr[5:0])
						FN_SLL:     res = b << instr[10:6];
						FN_ADDU:    res = a + b;
						FN_SUBU:    res = a - b;
						FN_AND:     res = a & b;
						FN_OR:      res = a | b;
						FN_XOR:     res = a ^ b;
						FN_SLT:     res = ($signed(a) < $signed(b)) ? 1 : 0;
						FN_JR: begin
							br = 1'b1;
							taken = 1'b1;
							target = a;
						end
						FN_SYSCALL: code = EXC_SYS;
						default:    code = EXC_RI;
					endcase
				end
				OP_J: begin
					br = 1'b1;
					taken = 1'b1;
					target = {npc[31:28], instr[25:0], 2'b00};
				end
				OP_BEQ: begin
					br = 1'b1;
					taken = (a == b);
				end
				OP_BNE: begin
					br = 1'b1;
					taken = (a != b);
				end
				OP_ADDIU: res = a + sext;
				OP_ORI:   res = a | {16'h0000, instr[15:0]};
				OP_LUI:   res = {instr[15:0], 16'h0000};
				default:  code = EXC_RI;
			endcase
			if (code != EXC_NONE) begin
				epc = prev_br ? pc - 4 : pc;	// delay slot reports its branch
			end else begin
				count++;
				if (!br && dst != '0) begin
					mregs[dst] = res;
					w.addr = dst;
					w.data = res;
					exp_q.push_back(w);
				end
				pc = npc;
				npc = taken ? target : npc + 4;
				prev_br = br;
			end
			steps++;
		end
	endtask

	task automatic run_program();
		exc_code_e        exp_code;
		logic [`XLEN-1:0] exp_epc;
		int               exp_retired;
		int               cycles;
		run_model(exp_code, exp_epc, exp_retired);
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		expect_eq("imem_addr", imem_addr, `RESET_PC);	// first RUN cycle
		cycles = 0;
		while (!halted && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		checks++;
		assert (halted) else begin
			errors++;
			$display("core did not halt within %0d cycles", WAIT_LIMIT);
		end
		expect_eq("exc_code", 32'(exc_code), 32'(exp_code));
		expect_eq("exc_epc", exc_epc, exp_epc);
		expect_eq("retired", retired, 32'(exp_retired));
		repeat (8) @(negedge clk);	// any late write shows up on the monitor
		checks++;
		assert (exp_q.size() == 0) else begin
			errors++;
			$display("%0d expected register writes never appeared", exp_q.size());
			exp_q.delete();
		end
	endtask

	// every write beat must match the head of the model's queue
	always @(negedge clk) begin
		if (!rst && wb_out.valid) begin
			checks++;
			assert (wb_out.addr != '0) else begin
				errors++;
				$display("a write to r0 was reported on wb_out");
			end
			assert (exp_q.size() > 0) else begin
				errors++;
				$display("unexpected write to r%0d when none was expected", wb_out.addr);
			end
			if (exp_q.size() > 0) begin
				exp_head = exp_q.pop_front();
				expect_eq("wb_out.addr", 32'(wb_out.addr), 32'(exp_head.addr));
				expect_eq("wb_out.data", wb_out.data, exp_head.data);
			end
		end
	end

	initial begin
		rst = 1'b1;
		start = 1'b0;
		for (int i = 0; i < 32; i++)
			mregs[i] = '0;
		load_program(0);
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		expect_eq("halted", 32'(halted), 32'd0);
		expect_eq("wb_out.valid", 32'(wb_out.valid), 32'd0);
		expect_eq("exc_code", 32'(exc_code), 32'(EXC_NONE));
		run_program();	// ALU ops, branches, jr, syscall
		load_program(1);
		run_program();	// bad word in a delay slot
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
